// ==== flist.f ====
rapcore_pkg.sv
spi_word.sv
command_parser.sv
move_buffer.sv
dda_timer.sv
quad_enc.sv
rapcore.sv
tb_rapcore.sv

// ==== Makefile ====
# Verilator simulation of the rapcore testbench

SIM_TOP ?= tb_rapcore
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(SIM_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(SIM_TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_rapcore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rapcore
  import rapcore_pkg::*;
();

  localparam int DEPTH = 4;
  localparam int ENC_BITS = 64;
  // SCK half period in CLK cycles
  localparam int HALF = 6;
  localparam int NROWS = 11;

  // Operation kinds of a table row
  localparam int K_CONFIG = 0;
  localparam int K_VERSION = 1;
  localparam int K_MOVE = 2;
  localparam int K_ENCODER = 3;
  localparam int K_OVERFLOW = 4;

  logic       CLK;
  logic       resetn;
  logic       sck;
  logic       cs;
  logic       copi;
  logic       cipo;
  logic       enc_a;
  logic       enc_b;
  logic       halt;
  logic       step;
  logic       dir;
  logic       enable;
  logic [7:0] current;
  logic [2:0] microsteps;
  logic       buffer_dtr;
  logic       move_done;
  logic       encoder_fault;

  // Pulse tallies
  int          step_total = 0;
  int          done_total = 0;
  logic [15:0] lfsr_state = 16'd74;
  // Gray code position of the encoder lines
  logic [1:0]  enc_phase = 2'd0;

  // Table columns hold the words to send and the expected values
  string                row_name [NROWS];
  int                   row_kind [NROWS];
  logic [WORD_BITS-1:0] row_w [NROWS][4];
  logic [WORD_BITS-1:0] row_e [NROWS][4];
  int                   row_count = 0;

  rapcore #(.MOVE_BUFFER_DEPTH(DEPTH), .ENC_BITS(ENC_BITS)) dut0 (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .halt(halt), .step(step), .dir(dir),
    .enable(enable), .current(current), .microsteps(microsteps),
    .buffer_dtr(buffer_dtr), .move_done(move_done), .encoder_fault(encoder_fault)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  // Pulses counted mid cycle
  always @(negedge CLK) begin
    if (step === 1'b1)
      step_total++;
    if (move_done === 1'b1)
      done_total++;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [WORD_BITS-1:0] exp,
                            input logic [WORD_BITS-1:0] act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_count(input string name, input logic signed [ENC_BITS-1:0] exp,
                             input logic signed [ENC_BITS-1:0] act);
    if (act !== exp)
      abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // Land just after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Carry out of the 64-bit accumulator is a step
  function automatic int dda_steps(input logic [WORD_BITS-1:0] dur,
                                   input logic [WORD_BITS-1:0] inc0,
                                   input logic [WORD_BITS-1:0] incinc);
    logic [WORD_BITS:0]   sum;
    logic [WORD_BITS-1:0] acc;
    logic [WORD_BITS-1:0] inc;
    int                   steps;
    acc = '0;
    inc = inc0;
    steps = 0;
    for (int t = 0; t < int'(dur); t++) begin
      sum = {1'b0, acc} + {1'b0, inc};
      if (sum[WORD_BITS])
        steps++;
      acc = sum[WORD_BITS-1:0];
      inc = inc + incinc;
    end
    return steps;
  endfunction

  // Halted timer pops nothing so the ring keeps at most DEPTH moves
  function automatic int accepted_moves(input int writes);
    return (writes > DEPTH) ? DEPTH : writes;
  endfunction

  // Mode 0 word sent MSB first up to the word strobe
  task automatic spi_xfer(input logic [WORD_BITS-1:0] tx, output logic [WORD_BITS-1:0] rx);
    int waited;
    cs = 1'b0;
    for (int i = WORD_BITS - 1; i >= 0; i--) begin
      copi = tx[i];
      wait_cycles(HALF);
      rx[i] = cipo;
      sck = 1'b1;
      wait_cycles(HALF);
      sck = 1'b0;
    end
    wait_cycles(HALF);
    cs = 1'b1;
    waited = 0;
    while (dut0.word_received !== 1'b1) begin
      if (waited >= 20)
        abort_run("timeout waiting for the SPI word strobe");
      wait_cycles(1);
      waited++;
    end
    // Parser registers settle
    wait_cycles(2);
  endtask

  task automatic send_move(input logic mdir, input logic [WORD_BITS-1:0] dur,
                           input logic [WORD_BITS-1:0] inc,
                           input logic [WORD_BITS-1:0] incinc,
                           output logic [WORD_BITS-1:0] reply);
    logic [WORD_BITS-1:0] rx;
    spi_xfer({CMD_COORDINATED_STEP, 55'd0, mdir}, rx);
    spi_xfer(dur, rx);
    spi_xfer(inc, rx);
    spi_xfer(incinc, reply);
  endtask

  task automatic wait_done(input int target, input int limit);
    int waited;
    waited = 0;
    while (done_total < target) begin
      if (waited >= limit)
        abort_run("timeout waiting for move_done");
      wait_cycles(1);
      waited++;
    end
  endtask

  task automatic add_row(input string name, input int kind,
                         input logic [WORD_BITS-1:0] w0, w1, w2, w3,
                         input logic [WORD_BITS-1:0] e0, e1, e2, e3);
    row_name[row_count] = name;
    row_kind[row_count] = kind;
    row_w[row_count] = '{w0, w1, w2, w3};
    row_e[row_count] = '{e0, e1, e2, e3};
    row_count++;
  endtask

  task automatic build_table();
    // Config rows expect reply, enable, current and microsteps
    add_row("enable_on", K_CONFIG, {CMD_MOTOR_ENABLE, 56'd1}, 64'd0, 64'd0, 64'd0,
            64'd0, 64'd1, 64'(DEFAULT_CURRENT), 64'(DEFAULT_MICROSTEPS));
    add_row("motorconfig", K_CONFIG, {CMD_MOTORCONFIG, 40'd0, 8'd200, 8'd5}, 64'd0,
            64'd0, 64'd0, 64'd0, 64'd1, 64'd200, 64'd5);
    add_row("api_version", K_VERSION, {CMD_API_VERSION, 56'd0}, 64'd0, 64'd0, 64'd0,
            {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH}, 64'd0, 64'd0, 64'd0);
    // Follows the version dummy so the reply must be back to zero
    add_row("unknown_header", K_CONFIG, {8'hEE, 56'h0000_0000_00FF07}, 64'd0, 64'd0,
            64'd0, 64'd0, 64'd1, 64'd200, 64'd5);
    // Move rows hold divisor, duration, increment and incrementincrement
    add_row("move_half", K_MOVE, 64'd40, 64'd20, 64'h8000_0000_0000_0000, 64'd0,
            64'd0, 64'd0, 64'd0, 64'd0);
    add_row("move_ramp", K_MOVE, 64'd3, 64'd30, 64'h1000_0000_0000_0000,
            64'h0200_0000_0000_0000, 64'd0, 64'd0, 64'd0, 64'd0);
    add_row("move_zero", K_MOVE, 64'd0, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0,
            64'd0, 64'd0, 64'd0, 64'd0);
    add_row("move_full", K_MOVE, 64'd7, 64'd16, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0,
            64'd0, 64'd0, 64'd0, 64'd0);
    add_row("move_decel", K_MOVE, 64'd1, 64'd24, 64'hC000_0000_0000_0000,
            64'hF800_0000_0000_0000, 64'd0, 64'd0, 64'd0, 64'd0);
    // Writes one more than the ring can take
    add_row("overflow", K_OVERFLOW, 64'd0, 64'd2, 64'h4000_0000_0000_0000, 64'd0,
            64'(DEPTH + 1), 64'd0, 64'd0, 64'd0);
    add_row("encoder", K_ENCODER, 64'd0, 64'd1, 64'd0, 64'd0, 64'd0, 64'd0, 64'd0, 64'd0);
  endtask

  initial begin
    logic [WORD_BITS-1:0] rx;
    int                   fwd;
    int                   rev;
    int                   dbit;
    int                   base_steps;
    int                   base_done;
    int                   waited;
    string                nm;
    resetn = 1'b0;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    halt = 1'b0;
    build_table();
    wait_cycles(4);
    resetn = 1'b1;
    wait_cycles(2);

    check_bit("reset_enable", 1'b0, enable);
    check_byte("reset_current", DEFAULT_CURRENT, current);
    check_byte("reset_microsteps", {5'd0, DEFAULT_MICROSTEPS}, {5'd0, microsteps});
    check_bit("reset_step", 1'b0, step);
    check_bit("reset_move_done", 1'b0, move_done);
    check_bit("reset_buffer_dtr", 1'b1, buffer_dtr);
    check_bit("reset_dir", 1'b0, dir);

    for (int r = 0; r < row_count; r++) begin
      nm = row_name[r];
      case (row_kind[r])
        K_CONFIG: begin
          spi_xfer(row_w[r][0], rx);
          check_word({nm, "_reply"}, row_e[r][0], rx);
          check_bit({nm, "_enable"}, row_e[r][1][0], enable);
          check_byte({nm, "_current"}, row_e[r][2][7:0], current);
          check_byte({nm, "_microsteps"}, row_e[r][3][7:0], {5'd0, microsteps});
        end
        K_VERSION: begin
          spi_xfer(row_w[r][0], rx);
          spi_xfer(row_w[r][1], rx);
          check_word({nm, "_reply"}, row_e[r][0], rx);
        end
        K_MOVE: begin
          spi_xfer({CMD_CLK_DIVISOR, 48'd0, row_w[r][0][7:0]}, rx);
          take_bits(1, dbit);
          base_steps = step_total;
          base_done = done_total;
          send_move(dbit[0], row_w[r][1], row_w[r][2], row_w[r][3], rx);
          wait_done(base_done + 1, 20000);
          wait_cycles(4);
          check_count({nm, "_steps"}, dda_steps(row_w[r][1], row_w[r][2], row_w[r][3]),
                      step_total - base_steps);
          check_count({nm, "_done"}, 1, done_total - base_done);
          check_bit({nm, "_dir"}, dbit[0], dir);
        end
        K_OVERFLOW: begin
          halt = 1'b1;
          base_done = done_total;
          for (int k = 1; k <= int'(row_e[r][0]); k++) begin
            send_move(1'b0, row_w[r][1], row_w[r][2], 64'd0, rx);
            wait_cycles(4);
            check_bit($sformatf("%s_dtr%0d", nm, k), accepted_moves(k) < DEPTH,
                      buffer_dtr);
          end
          wait_cycles(20);
          check_count({nm, "_halted"}, 0, done_total - base_done);
          halt = 1'b0;
          wait_done(base_done + accepted_moves(int'(row_e[r][0])), 20000);
          // Room for any stray completion
          wait_cycles(50);
          check_count({nm, "_done"}, accepted_moves(int'(row_e[r][0])),
                      done_total - base_done);
          check_bit({nm, "_dtr_end"}, 1'b1, buffer_dtr);
        end
        K_ENCODER: begin
          take_bits(5, fwd);
          take_bits(4, rev);
          // A leads B going forward
          for (int i = 0; i < fwd + rev; i++) begin
            enc_phase = (i < fwd) ? enc_phase + 2'd1 : enc_phase - 2'd1;
            enc_a = enc_phase[1] ^ enc_phase[0];
            enc_b = enc_phase[1];
            wait_cycles(4);
          end
          base_done = done_total;
          send_move(1'b0, row_w[r][1], 64'd0, 64'd0, rx);
          check_count({nm, "_count"}, fwd - rev, rx);
          wait_done(base_done + 1, 20000);
          check_bit({nm, "_fault_clear"}, 1'b0, encoder_fault);
          // Skipped state
          enc_a = ~enc_a;
          enc_b = ~enc_b;
          waited = 0;
          while (encoder_fault !== 1'b1) begin
            if (waited >= 10)
              abort_run("encoder_fault did not set after A and B changed together");
            wait_cycles(1);
            waited++;
          end
        end
        default: abort_run($sformatf("table row %0d has an unknown kind", r));
      endcase
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rapcore.sv ====
`timescale 1ns/1ps
`default_nettype none

module rapcore
  import rapcore_pkg::*;
#(
  parameter int MOVE_BUFFER_DEPTH = 4,
  parameter int ENC_BITS = 64
) (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs,
  input  logic       copi,
  output logic       cipo,
  input  logic       enc_a,
  input  logic       enc_b,
  input  logic       halt,
  output logic       step,
  output logic       dir,
  output logic       enable,
  output logic [7:0] current,
  output logic [2:0] microsteps,
  output logic       buffer_dtr,
  output logic       move_done,
  output logic       encoder_fault
);

  // SPI word path
  logic [WORD_BITS-1:0] word_data;
  logic [WORD_BITS-1:0] send_data;
  logic                 word_received;

  // Encoder position
  logic signed [ENC_BITS-1:0] encoder_count;
  logic [7:0]                 clock_divisor;

  // Parser to buffer
  logic                 wr_en;
  logic [WORD_BITS-1:0] wr_duration;
  logic [WORD_BITS-1:0] wr_increment;
  logic [WORD_BITS-1:0] wr_incrementincrement;
  logic                 wr_dir;

  // Buffer head to timer
  logic [WORD_BITS-1:0] head_duration;
  logic [WORD_BITS-1:0] head_increment;
  logic [WORD_BITS-1:0] head_incrementincrement;
  logic                 head_dir;
  logic                 valid;
  logic                 pop;

  spi_word u_spi_word (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .send_data(send_data), .word_data(word_data), .word_received(word_received)
  );

  command_parser #(.ENC_BITS(ENC_BITS)) u_command_parser (
    .CLK(CLK), .resetn(resetn), .word_data(word_data), .word_received(word_received),
    .send_data(send_data), .encoder_count(encoder_count), .enable(enable),
    .current(current), .microsteps(microsteps), .clock_divisor(clock_divisor),
    .wr_en(wr_en), .wr_duration(wr_duration), .wr_increment(wr_increment),
    .wr_incrementincrement(wr_incrementincrement), .wr_dir(wr_dir)
  );

  move_buffer #(.MOVE_BUFFER_DEPTH(MOVE_BUFFER_DEPTH)) u_move_buffer (
    .CLK(CLK), .resetn(resetn), .wr_en(wr_en), .wr_duration(wr_duration),
    .wr_increment(wr_increment), .wr_incrementincrement(wr_incrementincrement),
    .wr_dir(wr_dir), .pop(pop), .head_duration(head_duration),
    .head_increment(head_increment), .head_incrementincrement(head_incrementincrement),
    .head_dir(head_dir), .valid(valid), .buffer_dtr(buffer_dtr)
  );

  dda_timer u_dda_timer (
    .CLK(CLK), .resetn(resetn), .clock_divisor(clock_divisor), .halt(halt),
    .valid(valid), .head_duration(head_duration), .head_increment(head_increment),
    .head_incrementincrement(head_incrementincrement), .head_dir(head_dir),
    .pop(pop), .step(step), .dir(dir), .move_done(move_done)
  );

  quad_enc #(.ENC_BITS(ENC_BITS)) u_quad_enc (
    .CLK(CLK), .resetn(resetn), .a(enc_a), .b(enc_b),
    .count(encoder_count), .fault(encoder_fault)
  );

endmodule

`default_nettype wire

// ==== quad_enc.sv ====
`timescale 1ns/1ps
`default_nettype none

module quad_enc #(
  parameter int ENC_BITS = 64
) (
  input  logic                       CLK,
  input  logic                       resetn,
  input  logic                       a,
  input  logic                       b,
  output logic signed [ENC_BITS-1:0] count,
  output logic                       fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  // Last synchronized state
  logic       a_prev;
  logic       b_prev;
  logic       a_chg;
  logic       b_chg;
  logic       count_up;

  assign a_chg = a_sync[1] ^ a_prev;
  assign b_chg = b_sync[1] ^ b_prev;

  // A edge with A != B or B edge with A == B means A leads
  assign count_up = a_chg ? (a_sync[1] ^ b_sync[1]) : ~(a_sync[1] ^ b_sync[1]);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_sync <= 2'b00;
      b_sync <= 2'b00;
      a_prev <= 1'b0;
      b_prev <= 1'b0;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_sync <= {a_sync[0], a};
      b_sync <= {b_sync[0], b};
      a_prev <= a_sync[1];
      b_prev <= b_sync[1];
      // Both lines moved at once, skipped state
      if (a_chg && b_chg)
        fault <= 1'b1;
      else if (a_chg || b_chg)
        count <= count_up ? count + 1'b1 : count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== dda_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dda_timer
  import rapcore_pkg::*;
(
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic [7:0]           clock_divisor,
  input  logic                 halt,
  input  logic                 valid,
  input  logic [WORD_BITS-1:0] head_duration,
  input  logic [WORD_BITS-1:0] head_increment,
  input  logic [WORD_BITS-1:0] head_incrementincrement,
  input  logic                 head_dir,
  output logic                 pop,
  output logic                 step,
  output logic                 dir,
  output logic                 move_done
);

  logic [7:0]           prescale;
  logic                 tick;
  logic                 active;
  logic                 advance;
  logic [WORD_BITS-1:0] remaining;
  logic [WORD_BITS-1:0] accumulator;
  logic [WORD_BITS-1:0] increment;
  logic [WORD_BITS-1:0] incrementincrement;
  // Carry out of the accumulator is the step
  logic [WORD_BITS:0]   sum;

  // Tick every clock_divisor + 1 cycles
  assign tick = (prescale >= clock_divisor);

  // Idle timer takes the head entry unless halted
  assign pop = ~active & valid & ~halt;

  // One DDA iteration per tick unless halted
  assign advance = active & tick & ~halt & (remaining != '0);
  assign sum     = {1'b0, accumulator} + {1'b0, increment};

  // Prescaler
  always_ff @(posedge CLK) begin
    if (!resetn)
      prescale <= 8'd0;
    else if (tick)
      prescale <= 8'd0;
    else
      prescale <= prescale + 8'd1;
  end

  // Move sequencing and pulse outputs
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      active    <= 1'b0;
      step      <= 1'b0;
      move_done <= 1'b0;
      dir       <= 1'b0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (pop) begin
        active <= 1'b1;
        dir    <= head_dir;
      end else if (active && tick && !halt) begin
        step <= advance & sum[WORD_BITS];
        // Zero duration ends on its first tick
        if (remaining <= WORD_BITS'(1)) begin
          active    <= 1'b0;
          move_done <= 1'b1;
        end
      end
    end
  end

  // Accumulator, increment and tick count
  always_ff @(posedge CLK) begin
    if (pop) begin
      remaining          <= head_duration;
      accumulator        <= '0;
      increment          <= head_increment;
      incrementincrement <= head_incrementincrement;
    end else if (advance) begin
      accumulator <= sum[WORD_BITS-1:0];
      increment   <= increment + incrementincrement;
      remaining   <= remaining - WORD_BITS'(1);
    end
  end

endmodule

`default_nettype wire

// ==== move_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module move_buffer
  import rapcore_pkg::*;
#(
  parameter int MOVE_BUFFER_DEPTH = 4
) (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 wr_en,
  input  logic [WORD_BITS-1:0] wr_duration,
  input  logic [WORD_BITS-1:0] wr_increment,
  input  logic [WORD_BITS-1:0] wr_incrementincrement,
  input  logic                 wr_dir,
  input  logic                 pop,
  output logic [WORD_BITS-1:0] head_duration,
  output logic [WORD_BITS-1:0] head_increment,
  output logic [WORD_BITS-1:0] head_incrementincrement,
  output logic                 head_dir,
  output logic                 valid,
  output logic                 buffer_dtr
);

  localparam int IDX_BITS = $clog2(MOVE_BUFFER_DEPTH);

  logic [WORD_BITS-1:0]         mem_duration [MOVE_BUFFER_DEPTH];
  logic [WORD_BITS-1:0]         mem_increment [MOVE_BUFFER_DEPTH];
  logic [WORD_BITS-1:0]         mem_incrementincrement [MOVE_BUFFER_DEPTH];
  logic [MOVE_BUFFER_DEPTH-1:0] mem_dir;
  // Extra MSB tells full from empty
  logic [IDX_BITS:0]            wr_ptr;
  logic [IDX_BITS:0]            rd_ptr;
  logic                         full;
  logic                         empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[IDX_BITS] != rd_ptr[IDX_BITS]) &&
                 (wr_ptr[IDX_BITS-1:0] == rd_ptr[IDX_BITS-1:0]);

  assign valid      = ~empty;
  assign buffer_dtr = ~full;

  // Head entry shown to the timer
  assign head_duration           = mem_duration[rd_ptr[IDX_BITS-1:0]];
  assign head_increment          = mem_increment[rd_ptr[IDX_BITS-1:0]];
  assign head_incrementincrement = mem_incrementincrement[rd_ptr[IDX_BITS-1:0]];
  assign head_dir                = mem_dir[rd_ptr[IDX_BITS-1:0]];

  // Pointers, writes dropped while full
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en && !full)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop && !empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge CLK) begin
    if (wr_en && !full) begin
      mem_duration[wr_ptr[IDX_BITS-1:0]]           <= wr_duration;
      mem_increment[wr_ptr[IDX_BITS-1:0]]          <= wr_increment;
      mem_incrementincrement[wr_ptr[IDX_BITS-1:0]] <= wr_incrementincrement;
      mem_dir[wr_ptr[IDX_BITS-1:0]]                <= wr_dir;
    end
  end

endmodule

`default_nettype wire

// ==== command_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_parser
  import rapcore_pkg::*;
#(
  parameter int ENC_BITS = 64
) (
  input  logic                       CLK,
  input  logic                       resetn,
  input  logic [WORD_BITS-1:0]       word_data,
  input  logic                       word_received,
  output logic [WORD_BITS-1:0]       send_data,
  input  logic signed [ENC_BITS-1:0] encoder_count,
  output logic                       enable,
  output logic [7:0]                 current,
  output logic [2:0]                 microsteps,
  output logic [7:0]                 clock_divisor,
  output logic                       wr_en,
  output logic [WORD_BITS-1:0]       wr_duration,
  output logic [WORD_BITS-1:0]       wr_increment,
  output logic [WORD_BITS-1:0]       wr_incrementincrement,
  output logic                       wr_dir
);

  logic [7:0]                 header;
  logic [1:0]                 word_count;
  logic signed [ENC_BITS-1:0] encoder_store;
  logic [7:0]                 cmd;
  logic                       awaiting_more;
  logic                       in_move;

  // Header byte of the incoming word
  assign cmd = word_data[WORD_BITS-1 -: 8];

  // Multi word messages keep their header until complete
  assign awaiting_more = (header == CMD_COORDINATED_STEP) || (header == CMD_API_VERSION);
  assign in_move = (header == CMD_COORDINATED_STEP);

  // Message FSM and config registers
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      header        <= 8'd0;
      word_count    <= 2'd0;
      send_data     <= '0;
      enable        <= 1'b0;
      current       <= DEFAULT_CURRENT;
      microsteps    <= DEFAULT_MICROSTEPS;
      clock_divisor <= DEFAULT_CLOCK_DIVISOR;
      wr_en         <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (word_received) begin
        // Reply defaults to zero
        send_data <= '0;
        if (!awaiting_more) begin
          header     <= cmd;
          word_count <= 2'd1;
          case (cmd)
            CMD_MOTOR_ENABLE: enable <= word_data[0];
            CMD_CLK_DIVISOR: clock_divisor <= word_data[7:0];
            CMD_MOTORCONFIG: begin
              current    <= word_data[15:8];
              microsteps <= word_data[2:0];
            end
            // Version goes out during the dummy word
            CMD_API_VERSION: send_data[23:0] <= {VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
            default: ;
          endcase
        end else if (!in_move) begin
          // Dummy word ends the version request
          header     <= 8'd0;
          word_count <= 2'd0;
        end else begin
          word_count <= word_count + 2'd1;
          // Snapshot returns during the last move word
          if (word_count == 2'd2)
            send_data <= WORD_BITS'(encoder_store);
          if (word_count == 2'd3) begin
            header     <= 8'd0;
            word_count <= 2'd0;
            wr_en      <= 1'b1;
          end
        end
      end
    end
  end

  // Move fields toward the buffer
  always_ff @(posedge CLK) begin
    if (word_received) begin
      if (!awaiting_more && cmd == CMD_COORDINATED_STEP) begin
        wr_dir        <= word_data[0];
        encoder_store <= encoder_count;
      end
      if (in_move) begin
        case (word_count)
          2'd1: wr_duration <= word_data;
          2'd2: wr_increment <= word_data;
          2'd3: wr_incrementincrement <= word_data;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== spi_word.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_word
  import rapcore_pkg::*;
(
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 sck,
  input  logic                 cs,
  input  logic                 copi,
  output logic                 cipo,
  input  logic [WORD_BITS-1:0] send_data,
  output logic [WORD_BITS-1:0] word_data,
  output logic                 word_received
);

  localparam int CNT_BITS = $clog2(WORD_BITS + 1);

  // Two sync stages plus one delay stage for edge detect
  logic [2:0]          sck_r;
  logic [2:0]          cs_r;
  logic [1:0]          copi_r;
  logic                sck_rise;
  logic                sck_fall;
  logic                cs_rise;
  logic                cs_fall;
  logic                cs_active;
  logic [CNT_BITS-1:0] bit_cnt;
  logic                loaded;
  logic [WORD_BITS-1:0] tx_shift;

  assign sck_rise  = sck_r[1] & ~sck_r[2];
  assign sck_fall  = ~sck_r[1] & sck_r[2];
  assign cs_rise   = cs_r[1] & ~cs_r[2];
  assign cs_fall   = ~cs_r[1] & cs_r[2];
  assign cs_active = ~cs_r[1];

  // Strobe only after a complete word
  assign word_received = cs_rise & (bit_cnt == CNT_BITS'(WORD_BITS));

  // MSB of the reply is presented straight from send_data before the first fall
  assign cipo = loaded ? tx_shift[WORD_BITS-1] : send_data[WORD_BITS-1];

  // Pin synchronizers and transfer control
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_r   <= 3'b000;
      cs_r    <= 3'b111;
      copi_r  <= 2'b00;
      bit_cnt <= '0;
      loaded  <= 1'b0;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs};
      copi_r <= {copi_r[0], copi};
      if (cs_fall) begin
        bit_cnt <= '0;
        loaded  <= 1'b0;
      end else if (cs_active) begin
        // Saturate at a full word
        if (sck_rise && bit_cnt != CNT_BITS'(WORD_BITS))
          bit_cnt <= bit_cnt + CNT_BITS'(1);
        if (sck_fall)
          loaded <= 1'b1;
      end
    end
  end

  // Shift registers
  always_ff @(posedge CLK) begin
    // COPI sampled on rising SCK, MSB first
    if (cs_active && sck_rise)
      word_data <= {word_data[WORD_BITS-2:0], copi_r[1]};
    // First fall loads reply with its MSB already sent
    if (cs_active && sck_fall) begin
      if (!loaded)
        tx_shift <= {send_data[WORD_BITS-2:0], 1'b0};
      else
        tx_shift <= {tx_shift[WORD_BITS-2:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// ==== rapcore_pkg.sv ====
`default_nettype none

package rapcore_pkg;

  // Width of one SPI word
  localparam int WORD_BITS = 64;

  // Header codes
  // Taken from the top byte of the first word of a message
  localparam logic [7:0] CMD_COORDINATED_STEP = 8'd1;
  localparam logic [7:0] CMD_MOTOR_ENABLE = 8'd10;
  localparam logic [7:0] CMD_MOTORCONFIG = 8'd16;
  localparam logic [7:0] CMD_CLK_DIVISOR = 8'd20;
  localparam logic [7:0] CMD_API_VERSION = 8'd254;

  // API version reported to the host
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  // Reset values of the motor config registers
  // Divisor of 40 gives roughly 400 kHz ticks at 16 MHz
  localparam logic [7:0] DEFAULT_CLOCK_DIVISOR = 8'd40;

  // Phase current setting
  localparam logic [7:0] DEFAULT_CURRENT = 8'd140;

  // Microstep resolution code
  localparam logic [2:0] DEFAULT_MICROSTEPS = 3'd2;

  // Moves are three payload words after the header
  // Header word carries the direction in bit 0
  // Reply to the last word carries the encoder snapshot

  // Version reply sits in bits 23 to 0 of the second word

endpackage

`default_nettype wire
